//--- design/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    // Stages, one-hot active low in stage_active_n
    localparam int NUM_STAGES      = 6;
    localparam int STAGE_CONTROL   = 0;  // Also the reset stage
    localparam int STAGE_FETCH     = 1;
    localparam int STAGE_DECODE    = 2;
    localparam int STAGE_EXECUTE   = 3;
    localparam int STAGE_MEMORY    = 4;
    localparam int STAGE_WRITEBACK = 5;
    localparam logic [NUM_STAGES-1:0] STAGE_RESET_N = ~(NUM_STAGES'(1) << STAGE_CONTROL);

    // Memory fault number from the address checker
    localparam int MEM_FAULT_W    = 3;
    localparam int MF_PRESENT_BIT = 2;
    localparam int MF_STORE_BIT   = 1;
    localparam int MF_ACCESS_BIT  = 0;  // Clear means misaligned

    localparam int FAULT_NUM_W = 3;
    localparam logic [FAULT_NUM_W-1:0] FAULT_INSTR_MISALIGNED = 3'd0;
    localparam logic [FAULT_NUM_W-1:0] FAULT_INSTR_ACCESS     = 3'd1;
    localparam logic [FAULT_NUM_W-1:0] FAULT_ILLEGAL_INSTR    = 3'd2;
    localparam logic [FAULT_NUM_W-1:0] FAULT_LOAD_MISALIGNED  = 3'd4;
    localparam logic [FAULT_NUM_W-1:0] FAULT_LOAD_ACCESS      = 3'd5;
    localparam logic [FAULT_NUM_W-1:0] FAULT_STORE_MISALIGNED = 3'd6;
    localparam logic [FAULT_NUM_W-1:0] FAULT_STORE_ACCESS     = 3'd7;

    localparam int CTRL_OP_W = 2;
    localparam logic [CTRL_OP_W-1:0] CTRL_NONE    = 2'd0;
    localparam logic [CTRL_OP_W-1:0] CTRL_SW_INT  = 2'd1;
    localparam logic [CTRL_OP_W-1:0] CTRL_EXT_INT = 2'd2;
    localparam logic [CTRL_OP_W-1:0] CTRL_FAULT   = 2'd3;

    // Cause is {interrupt, code[3:0]}
    localparam int CAUSE_W = 5;
    localparam logic [CAUSE_W-1:0] CAUSE_SW_INT  = {1'b1, 4'd3};
    localparam logic [CAUSE_W-1:0] CAUSE_EXT_INT = {1'b1, 4'd11};

    localparam int TRAP_COUNT_W = 8;

    localparam logic [31:0] MEM_LIMIT = 32'h0001_0000;  // First faulting address

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // RV32I base opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

`default_nettype wire

//--- design/stage_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stage_sequencer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  illegal_instr,
    input  logic [cpu_ctrl_pkg::MEM_FAULT_W-1:0]  mem_fault_num,
    input  logic                                  ext_int,
    input  logic                                  sw_int,
    output logic [cpu_ctrl_pkg::NUM_STAGES-1:0]   stage_active_n,
    output logic [cpu_ctrl_pkg::CTRL_OP_W-1:0]    control_op,
    output logic [cpu_ctrl_pkg::FAULT_NUM_W-1:0]  fault_num
);
    import cpu_ctrl_pkg::*;

    logic                   in_progress;        // Second cycle of the stage
    logic [NUM_STAGES-1:0]  next_stage_n;
    logic                   mem_fault;
    logic                   fetch_fault;
    logic                   memory_fault;
    logic                   instr_fault;
    logic                   active_fault;
    logic [FAULT_NUM_W-1:0] next_fault_num;
    logic [CTRL_OP_W-1:0]   next_control_op;
    logic                   update_control_op;

    // Rotate toward the higher index, writeback wraps to control
    assign next_stage_n = {stage_active_n[NUM_STAGES-2:0], stage_active_n[NUM_STAGES-1]};

    assign mem_fault    = mem_fault_num[MF_PRESENT_BIT];
    assign fetch_fault  = mem_fault & ~stage_active_n[STAGE_FETCH];
    assign memory_fault = mem_fault & ~stage_active_n[STAGE_MEMORY];
    assign instr_fault  = illegal_instr & stage_active_n[STAGE_CONTROL];  // Ignored in control
    assign active_fault = fetch_fault | memory_fault | instr_fault;

    always_comb begin
        if (instr_fault) begin
            next_fault_num = FAULT_ILLEGAL_INSTR;  // Wins over memory faults
        end else if (memory_fault) begin
            next_fault_num = {1'b1, mem_fault_num[MF_STORE_BIT], mem_fault_num[MF_ACCESS_BIT]};
        end else begin
            next_fault_num = {2'b00, mem_fault_num[MF_ACCESS_BIT]};  // Fetch fault
        end
    end

    always_comb begin
        if (active_fault) begin
            next_control_op = CTRL_FAULT;
        end else if (ext_int) begin
            next_control_op = CTRL_EXT_INT;
        end else if (sw_int) begin
            next_control_op = CTRL_SW_INT;
        end else begin
            next_control_op = CTRL_NONE;
        end
    end

    assign update_control_op = in_progress & (~next_stage_n[STAGE_CONTROL] | active_fault);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_progress    <= 1'b0;
            stage_active_n <= STAGE_RESET_N;
            control_op     <= CTRL_NONE;
            fault_num      <= '0;
        end else begin
            in_progress <= ~in_progress;
            if (in_progress) begin
                if (active_fault) begin
                    stage_active_n <= STAGE_RESET_N;  // Straight to control
                end else begin
                    stage_active_n <= next_stage_n;
                end
            end
            if (active_fault) begin
                fault_num <= next_fault_num;  // Captured in either stage cycle
            end
            if (update_control_op) begin
                control_op <= next_control_op;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_fault_check.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fault_check (
    input  logic [cpu_ctrl_pkg::NUM_STAGES-1:0]  stage_active_n,
    input  logic [31:0]                          pc,
    input  logic [31:0]                          data_addr,
    input  logic [1:0]                           data_size,
    input  logic                                 data_en,
    input  logic                                 data_store,
    output logic [cpu_ctrl_pkg::MEM_FAULT_W-1:0] mem_fault_num
);
    import cpu_ctrl_pkg::*;

    logic        check_en;
    logic [31:0] addr;
    logic [1:0]  size;
    logic        store;
    logic        misaligned;
    logic        out_of_range;
    logic        fault;

    // Pick the access that belongs to the current stage
    always_comb begin
        check_en = 1'b0;
        addr     = pc;
        size     = SIZE_WORD;
        store    = 1'b0;
        if (!stage_active_n[STAGE_FETCH]) begin
            check_en = 1'b1;  // Instruction word fetch
        end else if (!stage_active_n[STAGE_MEMORY] && data_en) begin
            check_en = 1'b1;
            addr     = data_addr;
            size     = data_size;
            store    = data_store;
        end
    end

    always_comb begin
        case (size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = addr[0];
            default:   misaligned = |addr[1:0];  // Word
        endcase
    end

    assign out_of_range = (addr >= MEM_LIMIT);
    assign fault        = check_en & (misaligned | out_of_range);

    always_comb begin
        mem_fault_num                 = '0;
        mem_fault_num[MF_PRESENT_BIT] = fault;
        mem_fault_num[MF_STORE_BIT]   = fault & store;
        mem_fault_num[MF_ACCESS_BIT]  = fault & ~misaligned;  // Misalignment reported first
    end

endmodule

`default_nettype wire

//--- design/instr_legal_check.sv
`timescale 1ns/1ps
`default_nettype none

module instr_legal_check (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    output logic       illegal_instr
);
    import cpu_ctrl_pkg::*;

    always_comb begin
        case (opcode)
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL,
            OPC_OP_IMM,
            OPC_OP: begin
                illegal_instr = 1'b0;  // Every funct3 has a meaning
            end
            OPC_JALR: begin
                illegal_instr = (funct3 != 3'd0);
            end
            OPC_BRANCH: begin
                illegal_instr = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            OPC_LOAD: begin
                // LB LH LW LBU LHU only
                illegal_instr = (funct3 == 3'd3) || (funct3 >= 3'd6);
            end
            OPC_STORE: begin
                illegal_instr = (funct3 >= 3'd3);  // SB SH SW only
            end
            default: begin
                illegal_instr = 1'b1;  // Not an RV32I opcode
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/irq_pending.sv
`timescale 1ns/1ps
`default_nettype none

module irq_pending (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ext_int_req,
    input  logic                                sw_int_req,
    input  logic [cpu_ctrl_pkg::NUM_STAGES-1:0] stage_active_n,
    input  logic [cpu_ctrl_pkg::CTRL_OP_W-1:0]  control_op,
    output logic                                ext_int,
    output logic                                sw_int
);
    import cpu_ctrl_pkg::*;

    logic in_control;
    logic ext_clear;
    logic sw_clear;

    assign in_control = ~stage_active_n[STAGE_CONTROL];
    assign ext_clear  = in_control & (control_op == CTRL_EXT_INT);
    assign sw_clear   = in_control & (control_op == CTRL_SW_INT);

    // Clear wins, so a request arriving while being served is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ext_int <= 1'b0;
            sw_int  <= 1'b0;
        end else begin
            if (ext_clear) begin
                ext_int <= 1'b0;
            end else if (ext_int_req) begin
                ext_int <= 1'b1;
            end
            if (sw_clear) begin
                sw_int <= 1'b0;
            end else if (sw_int_req) begin
                sw_int <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/trap_cause_reg.sv
`timescale 1ns/1ps
`default_nettype none

module trap_cause_reg (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [cpu_ctrl_pkg::NUM_STAGES-1:0]    stage_active_n,
    input  logic [cpu_ctrl_pkg::CTRL_OP_W-1:0]     control_op,
    input  logic [cpu_ctrl_pkg::FAULT_NUM_W-1:0]   fault_num,
    output logic [cpu_ctrl_pkg::CAUSE_W-1:0]       trap_cause,
    output logic [cpu_ctrl_pkg::TRAP_COUNT_W-1:0]  trap_count
);
    import cpu_ctrl_pkg::*;

    logic               control_active;
    logic               control_prev;   // Control stage in the last cycle
    logic               control_entry;
    logic [CAUSE_W-1:0] next_cause;

    assign control_active = ~stage_active_n[STAGE_CONTROL];
    assign control_entry  = control_active & ~control_prev;

    always_comb begin
        case (control_op)
            CTRL_SW_INT:  next_cause = CAUSE_SW_INT;
            CTRL_EXT_INT: next_cause = CAUSE_EXT_INT;
            default:      next_cause = CAUSE_W'(fault_num);  // Exception code is the fault number
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            control_prev <= 1'b1;  // Reset lands in control, not a trap
            trap_cause   <= '0;
            trap_count   <= '0;
        end else begin
            control_prev <= control_active;
            if (control_entry && (control_op != CTRL_NONE)) begin
                trap_cause <= next_cause;
                trap_count <= trap_count + 1'b1;  // Wraps
            end
        end
    end

endmodule

`default_nettype wire

//--- design/ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [31:0]                            pc,
    input  logic [6:0]                             opcode,
    input  logic [2:0]                             funct3,
    input  logic [31:0]                            data_addr,
    input  logic [1:0]                             data_size,
    input  logic                                   data_en,
    input  logic                                   data_store,
    input  logic                                   ext_int_req,
    input  logic                                   sw_int_req,
    output logic [cpu_ctrl_pkg::NUM_STAGES-1:0]    stage_active_n,
    output logic [cpu_ctrl_pkg::CTRL_OP_W-1:0]     control_op,
    output logic [cpu_ctrl_pkg::FAULT_NUM_W-1:0]   fault_num,
    output logic [cpu_ctrl_pkg::CAUSE_W-1:0]       trap_cause,
    output logic [cpu_ctrl_pkg::TRAP_COUNT_W-1:0]  trap_count
);
    import cpu_ctrl_pkg::*;

    logic [MEM_FAULT_W-1:0] mem_fault_num;
    logic                   illegal_instr;
    logic                   ext_int;        // Latched request levels
    logic                   sw_int;

    stage_sequencer stage_sequencer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .illegal_instr  (illegal_instr),
        .mem_fault_num  (mem_fault_num),
        .ext_int        (ext_int),
        .sw_int         (sw_int),
        .stage_active_n (stage_active_n),
        .control_op     (control_op),
        .fault_num      (fault_num)
    );

    mem_fault_check mem_fault_check_inst (
        .stage_active_n (stage_active_n),
        .pc             (pc),
        .data_addr      (data_addr),
        .data_size      (data_size),
        .data_en        (data_en),
        .data_store     (data_store),
        .mem_fault_num  (mem_fault_num)
    );

    instr_legal_check instr_legal_check_inst (
        .opcode        (opcode),
        .funct3        (funct3),
        .illegal_instr (illegal_instr)
    );

    irq_pending irq_pending_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ext_int_req    (ext_int_req),
        .sw_int_req     (sw_int_req),
        .stage_active_n (stage_active_n),
        .control_op     (control_op),
        .ext_int        (ext_int),
        .sw_int         (sw_int)
    );

    trap_cause_reg trap_cause_reg_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stage_active_n (stage_active_n),
        .control_op     (control_op),
        .fault_num      (fault_num),
        .trap_cause     (trap_cause),
        .trap_count     (trap_count)
    );

endmodule

`default_nettype wire

//--- sim/tb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_top;
    import cpu_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = 40 * 12 + 60;  // 40 rounds plus margin

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [31:0]             pc;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [31:0]             data_addr;
    logic [1:0]              data_size;
    logic                    data_en;
    logic                    data_store;
    logic                    ext_int_req;
    logic                    sw_int_req;
    logic [NUM_STAGES-1:0]   stage_active_n;
    logic [CTRL_OP_W-1:0]    control_op;
    logic [FAULT_NUM_W-1:0]  fault_num;
    logic [CAUSE_W-1:0]      trap_cause;
    logic [TRAP_COUNT_W-1:0] trap_count;

    logic [15:0]             lfsr_state = 16'd51;
    logic [TRAP_COUNT_W-1:0] exp_count;
    int                      checks;
    int                      errors;
    int                      tests;

    ctrl_top ctrl_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc             (pc),
        .opcode         (opcode),
        .funct3         (funct3),
        .data_addr      (data_addr),
        .data_size      (data_size),
        .data_en        (data_en),
        .data_store     (data_store),
        .ext_int_req    (ext_int_req),
        .sw_int_req     (sw_int_req),
        .stage_active_n (stage_active_n),
        .control_op     (control_op),
        .fault_num      (fault_num),
        .trap_cause     (trap_cause),
        .trap_count     (trap_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [6:0] legal_opcode(input int idx);
        case (idx)
            0:       return 7'b0110111;  // LUI
            1:       return 7'b0010111;  // AUIPC
            2:       return 7'b1101111;  // JAL
            3:       return 7'b1100111;  // JALR
            4:       return 7'b1100011;  // BRANCH
            5:       return 7'b0000011;  // LOAD
            6:       return 7'b0100011;  // STORE
            7:       return 7'b0010011;  // OP-IMM
            default: return 7'b0110011;  // OP
        endcase
    endfunction

    function automatic logic [NUM_STAGES-1:0] stage_vec(input int idx);
        return ~(NUM_STAGES'(1) << idx);
    endfunction

    // Expected fault code, -1 when the access is clean
    function automatic int fault_model(input logic [31:0] addr, input logic [1:0] size,
                                       input logic store, input logic data_side);
        logic misaligned;
        logic access;
        if (size == SIZE_HALF) begin
            misaligned = addr[0];
        end else if (size == SIZE_WORD) begin
            misaligned = (addr[1:0] != 2'b00);
        end else begin
            misaligned = 1'b0;
        end
        access = !misaligned && (addr >= 32'h0001_0000);
        if (!misaligned && !access) begin
            return -1;
        end
        return data_side ? 4 + 2 * int'(store) + int'(access) : int'(access);
    endfunction

    function automatic logic [CAUSE_W-1:0] cause_model(input logic [CTRL_OP_W-1:0] op,
                                                       input int fault);
        if (op == CTRL_SW_INT) begin
            return {1'b1, 4'd3};
        end else if (op == CTRL_EXT_INT) begin
            return {1'b1, 4'd11};
        end
        return {2'b00, 3'(fault)};  // Exception code equals fault number
    endfunction

    task automatic check_stage(input logic [NUM_STAGES-1:0] exp, input string msg);
        checks++;
        if (stage_active_n !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, stage_active_n %b expected %b",
                     $time, msg, stage_active_n, exp);
        end
    endtask

    task automatic check_op(input logic [CTRL_OP_W-1:0] exp, input string msg);
        checks++;
        if (control_op !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, control_op %0d expected %0d",
                     $time, msg, control_op, exp);
        end
    endtask

    task automatic check_fault(input logic [FAULT_NUM_W-1:0] exp, input string msg);
        checks++;
        if (fault_num !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, fault_num %0d expected %0d",
                     $time, msg, fault_num, exp);
        end
    endtask

    task automatic check_cause(input logic [CAUSE_W-1:0] exp, input string msg);
        checks++;
        if (trap_cause !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, trap_cause %h expected %h",
                     $time, msg, trap_cause, exp);
        end
    endtask

    task automatic check_count(input logic [TRAP_COUNT_W-1:0] exp, input string msg);
        checks++;
        if (trap_count !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, trap_count %0d expected %0d",
                     $time, msg, trap_count, exp);
        end
    endtask

    // Legal, aligned, in-range inputs with no requests
    task automatic drive_random();
        logic [31:0] r;
        random_bits(14, r);
        pc = {16'd0, r[13:0], 2'b00};
        random_bits(4, r);
        opcode = legal_opcode(int'(r[3:0]) % 9);
        funct3 = 3'd0;
        random_bits(14, r);
        data_addr = {16'd0, r[13:0], 2'b00};
        data_size = SIZE_WORD;
        random_bits(2, r);
        data_en     = r[1];
        data_store  = r[0];
        ext_int_req = 1'b0;
        sw_int_req  = 1'b0;
    endtask

    // Stage must hold for both cycles
    task automatic pass_stage(input int idx);
        check_stage(stage_vec(idx), "stage first cycle");
        @(negedge clk);
        check_stage(stage_vec(idx), "stage second cycle");
        @(negedge clk);
    endtask

    task automatic run_to_stage(input int target);
        for (int idx = STAGE_FETCH; idx < target; idx++) begin
            drive_random();
            pass_stage(idx);
        end
    endtask

    // Starts in control cycle 1, ends in fetch cycle 1
    task automatic finish_control(input logic [CTRL_OP_W-1:0] exp_op,
                                  input logic [CAUSE_W-1:0] exp_cause);
        check_stage(stage_vec(STAGE_CONTROL), "control entry");
        check_op(exp_op, "control op at entry");
        drive_random();
        @(negedge clk);
        check_stage(stage_vec(STAGE_CONTROL), "control second cycle");
        if (exp_op != CTRL_NONE) begin
            exp_count = exp_count + 8'd1;
            check_cause(exp_cause, "trap cause");
        end
        check_count(exp_count, "trap count");
        drive_random();
        @(negedge clk);
    endtask

    task automatic fetch_trap(input logic [31:0] bad_pc, input logic bad_opcode);
        int exp;
        drive_random();
        pc = bad_pc;
        if (bad_opcode) begin
            opcode = 7'h7f;
        end
        exp = bad_opcode ? 2 : fault_model(bad_pc, SIZE_WORD, 1'b0, 1'b0);
        pass_stage(STAGE_FETCH);
        check_fault(FAULT_NUM_W'(exp), "fetch fault number");
        finish_control(CTRL_FAULT, cause_model(CTRL_FAULT, exp));
    endtask

    task automatic decode_trap(input logic [6:0] opc, input logic [2:0] f3);
        run_to_stage(STAGE_DECODE);
        drive_random();
        opcode = opc;
        funct3 = f3;
        pass_stage(STAGE_DECODE);
        check_fault(FAULT_NUM_W'(2), "illegal instruction fault number");
        finish_control(CTRL_FAULT, cause_model(CTRL_FAULT, 2));
    endtask

    // Starts in memory cycle 1
    task automatic memory_access(input logic [31:0] addr, input logic [1:0] size,
                                 input logic store, input logic en,
                                 input logic [CTRL_OP_W-1:0] clean_op);
        int exp;
        drive_random();
        data_addr  = addr;
        data_size  = size;
        data_store = store;
        data_en    = en;
        exp = en ? fault_model(addr, size, store, 1'b1) : -1;
        pass_stage(STAGE_MEMORY);
        if (exp >= 0) begin
            check_fault(FAULT_NUM_W'(exp), "memory fault number");
            finish_control(CTRL_FAULT, cause_model(CTRL_FAULT, exp));
        end else begin
            drive_random();
            pass_stage(STAGE_WRITEBACK);
            finish_control(clean_op, cause_model(clean_op, 0));
        end
    endtask

    task automatic pulse_in_stage(input int idx, input logic ext, input logic sw);
        drive_random();
        ext_int_req = ext;
        sw_int_req  = sw;
        check_stage(stage_vec(idx), "request pulse");
        @(negedge clk);
        ext_int_req = 1'b0;
        sw_int_req  = 1'b0;
        check_stage(stage_vec(idx), "after request pulse");
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic clean_rotation();
        int e0;
        e0 = errors;
        check_fault('0, "fault number after reset");
        check_count('0, "trap count after reset");
        finish_control(CTRL_NONE, '0);
        for (int r = 0; r < 3; r++) begin
            run_to_stage(NUM_STAGES);  // Writeback wraps to control
            finish_control(CTRL_NONE, '0);
        end
        report_test("clean_rotation", e0);
    endtask

    task automatic fetch_faults();
        int e0;
        e0 = errors;
        fetch_trap(32'h0000_0102, 1'b0);
        fetch_trap(32'h0001_0000, 1'b0);
        fetch_trap(32'h0000_FFFD, 1'b0);
        fetch_trap(32'hFFFF_FFF0, 1'b0);
        report_test("fetch_faults", e0);
    endtask

    task automatic illegal_instructions();
        int e0;
        e0 = errors;
        decode_trap(7'h7f, 3'd0);
        decode_trap(OPC_LOAD, 3'd3);
        decode_trap(OPC_STORE, 3'd4);
        fetch_trap(32'h0000_0101, 1'b1);  // Illegal wins over misaligned pc
        report_test("illegal_instructions", e0);
    endtask

    task automatic memory_faults();
        int e0;
        e0 = errors;
        for (int en = 1; en >= 0; en--) begin
            run_to_stage(STAGE_MEMORY);
            memory_access(32'h0000_0102, SIZE_WORD, 1'b0, 1'(en), CTRL_NONE);
            run_to_stage(STAGE_MEMORY);
            memory_access(32'h0001_0000, SIZE_WORD, 1'b0, 1'(en), CTRL_NONE);
            run_to_stage(STAGE_MEMORY);
            memory_access(32'h0000_0101, SIZE_HALF, 1'b1, 1'(en), CTRL_NONE);
            run_to_stage(STAGE_MEMORY);
            memory_access(32'h0002_0000, SIZE_BYTE, 1'b1, 1'(en), CTRL_NONE);
        end
        report_test("memory_faults", e0);
    endtask

    task automatic interrupt_priority();
        int e0;
        e0 = errors;
        run_to_stage(STAGE_EXECUTE);
        pulse_in_stage(STAGE_EXECUTE, 1'b0, 1'b1);
        memory_access(32'h0, SIZE_WORD, 1'b0, 1'b0, CTRL_SW_INT);
        // Both pending, external first
        run_to_stage(STAGE_EXECUTE);
        pulse_in_stage(STAGE_EXECUTE, 1'b1, 1'b1);
        memory_access(32'h0, SIZE_WORD, 1'b0, 1'b0, CTRL_EXT_INT);
        run_to_stage(NUM_STAGES);
        finish_control(CTRL_SW_INT, cause_model(CTRL_SW_INT, 0));
        // Fault beats both, requests stay latched
        run_to_stage(STAGE_EXECUTE);
        pulse_in_stage(STAGE_EXECUTE, 1'b1, 1'b1);
        memory_access(32'h0000_0102, SIZE_WORD, 1'b0, 1'b1, CTRL_NONE);
        run_to_stage(NUM_STAGES);
        finish_control(CTRL_EXT_INT, cause_model(CTRL_EXT_INT, 0));
        run_to_stage(NUM_STAGES);
        finish_control(CTRL_SW_INT, cause_model(CTRL_SW_INT, 0));
        report_test("interrupt_priority", e0);
    endtask

    initial begin
        rst_n       = 1'b0;
        pc          = '0;
        opcode      = 7'b0010011;
        funct3      = '0;
        data_addr   = '0;
        data_size   = SIZE_WORD;
        data_en     = 1'b0;
        data_store  = 1'b0;
        ext_int_req = 1'b0;
        sw_int_req  = 1'b0;
        exp_count   = '0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Control stage, first cycle
        clean_rotation();
        fetch_faults();
        illegal_instructions();
        memory_faults();
        interrupt_priority();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/cpu_ctrl_pkg.sv
design/stage_sequencer.sv
design/mem_fault_check.sv
design/instr_legal_check.sv
design/irq_pending.sv
design/trap_cause_reg.sv
design/ctrl_top.sv
sim/tb_ctrl_top.sv

//--- Makefile
TOP := tb_ctrl_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f filelist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'All checks passed'

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
